// ==== design/timer_pkg.sv ====
`default_nettype none

package timer_pkg;

    // edge select for start, stop and capture sources.
    typedef enum logic [1:0] {
        EDGE_RISE = 2'b00, // low to high.
        EDGE_FALL = 2'b01, // high to low.
        EDGE_NONE = 2'b10, // never fires.
        EDGE_BOTH = 2'b11  // any change.
    } edge_sel_t;

    // source select codes.
    // code 2 .. 2+INNER_NUM-1 picks inner input (code-2), anything above reads zero.
    localparam int SRC_EXT_A = 0;
    localparam int SRC_EXT_B = 1;

    // capture slots per channel, filled in rotation.
    localparam int CAP_SLOTS = 3;

    // slot pointer, counts 0..CAP_SLOTS-1.
    typedef logic [1:0] slot_idx_t;

endpackage

`default_nettype wire

// ==== design/cap_bank_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// one channel's capture slots and status, read by the snapshot block.
interface cap_bank_if #(
    parameter int COUNT_WIDTH = 32
) ();
    import timer_pkg::*;

    logic [COUNT_WIDTH-1:0] cap0;   // slot 0.
    logic [COUNT_WIDTH-1:0] cap1;   // slot 1.
    logic [COUNT_WIDTH-1:0] cap2;   // slot 2.
    logic [CAP_SLOTS-1:0]   status; // one bit per slot, set on capture.

    modport producer (
        output cap0,
        output cap1,
        output cap2,
        output status
    );

    modport consumer (
        input cap0,
        input cap1,
        input cap2,
        input status
    );

endinterface

`default_nettype wire

// ==== design/capture_timebase.sv ====
`timescale 1ns/1ns
`default_nettype none

module capture_timebase #(
    parameter int COUNT_WIDTH = 32,
    parameter int INNER_NUM   = 4,
    localparam int SEL_WIDTH  = $clog2(INNER_NUM + 2)
) (
    input  wire                      i_clk,
    input  wire                      i_rst_n,
    input  wire                      i_enable,
    input  wire                      i_ext_a,
    input  wire                      i_ext_b,
    input  wire  [INNER_NUM-1:0]     i_inner_din,
    input  wire  [SEL_WIDTH-1:0]     i_src_sel_start,
    input  wire  [SEL_WIDTH-1:0]     i_src_sel_stop,
    input  timer_pkg::edge_sel_t     i_edge_start,
    input  timer_pkg::edge_sel_t     i_edge_stop,
    output logic                     o_run,
    output logic [COUNT_WIDTH-1:0]   o_count
);
    import timer_pkg::*;

    logic       start_src;
    logic       stop_src;
    logic [1:0] start_sync; // [0] is d1, [1] is d2.
    logic [1:0] stop_sync;
    logic       start_hit;
    logic       stop_hit;

    // source mux, out-of-range codes read zero.
    function automatic logic pick_src(input logic [SEL_WIDTH-1:0] sel);
        logic bit_v;
        bit_v = 1'b0;
        if (int'(sel) == SRC_EXT_A) begin
            bit_v = i_ext_a;
        end else if (int'(sel) == SRC_EXT_B) begin
            bit_v = i_ext_b;
        end else begin
            for (int i = 0; i < INNER_NUM; i++) begin
                if (int'(sel) == i + 2) begin
                    bit_v = i_inner_din[i];
                end
            end
        end
        return bit_v;
    endfunction

    function automatic logic edge_hit(input edge_sel_t mode, input logic d1, input logic d2);
        logic hit;
        case (mode)
            EDGE_RISE: hit = d1 & ~d2;
            EDGE_FALL: hit = ~d1 & d2;
            EDGE_BOTH: hit = d1 ^ d2;
            default:   hit = 1'b0; // EDGE_NONE.
        endcase
        return hit;
    endfunction

    always_comb begin
        start_src = pick_src(i_src_sel_start);
        stop_src  = pick_src(i_src_sel_stop);
    end

    // two-stage history of each selected source.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            start_sync <= 2'b00;
            stop_sync  <= 2'b00;
        end else if (!i_enable) begin
            start_sync <= 2'b00;
            stop_sync  <= 2'b00;
        end else begin
            start_sync <= {start_sync[0], start_src};
            stop_sync  <= {stop_sync[0], stop_src};
        end
    end

    // each source decoded with its own edge field.
    assign start_hit = edge_hit(i_edge_start, start_sync[0], start_sync[1]);
    assign stop_hit  = edge_hit(i_edge_stop, stop_sync[0], stop_sync[1]);

    // run flag.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_run <= 1'b0;
        end else if (!i_enable) begin
            o_run <= 1'b0;
        end else if (stop_hit) begin
            o_run <= 1'b0; // stop beats a same-cycle start.
        end else if (start_hit) begin
            o_run <= 1'b1;
        end
    end

    // free-running counter, wraps to zero after all ones.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_count <= '0;
        end else if (!i_enable) begin
            o_count <= '0;
        end else if (o_run) begin
            o_count <= o_count + 1'b1;
        end
    end

    // disabling the timer halts it on the very next edge.
    a_run_off_when_disabled: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !$past(i_enable) |-> !o_run
    ) else $error("run still high after enable was low");

endmodule

`default_nettype wire

// ==== design/capture_channel.sv ====
`timescale 1ns/1ns
`default_nettype none

module capture_channel #(
    parameter int COUNT_WIDTH = 32,
    parameter int INNER_NUM   = 4,
    localparam int SEL_WIDTH  = $clog2(INNER_NUM + 2)
) (
    input  wire                            i_clk,
    input  wire                            i_rst_n,
    input  wire                            i_enable,
    input  wire                            i_run,
    input  wire  [COUNT_WIDTH-1:0]         i_count,
    input  wire                            i_ext_a,
    input  wire                            i_ext_b,
    input  wire  [INNER_NUM-1:0]           i_inner_din,
    input  wire  [SEL_WIDTH-1:0]           i_src_sel,
    input  timer_pkg::edge_sel_t           i_edge,
    input  wire  [timer_pkg::CAP_SLOTS-1:0] i_overflow_ctrl, // 1 overwrites, 0 keeps.
    input  wire  [timer_pkg::CAP_SLOTS-1:0] i_read_flag,
    cap_bank_if.producer                   o_bank
);
    import timer_pkg::*;

    logic                                  src_bit;
    logic [1:0]                            src_sync; // [0] is d1, [1] is d2.
    logic                                  edge_det;
    logic                                  cap_hit;
    slot_idx_t                             ptr_q;
    logic [CAP_SLOTS-1:0]                  status_q;
    logic [CAP_SLOTS-1:0][COUNT_WIDTH-1:0] slot_q;
    logic [CAP_SLOTS-1:0]                  rd_q;
    logic [CAP_SLOTS-1:0]                  rd_rise;
    logic [CAP_SLOTS-1:0]                  set_bit;

    always_comb begin
        src_bit = 1'b0;
        if (int'(i_src_sel) == SRC_EXT_A) begin
            src_bit = i_ext_a;
        end else if (int'(i_src_sel) == SRC_EXT_B) begin
            src_bit = i_ext_b;
        end else begin
            for (int i = 0; i < INNER_NUM; i++) begin
                if (int'(i_src_sel) == i + 2) begin
                    src_bit = i_inner_din[i];
                end
            end
        end
    end

    always_comb begin
        case (i_edge)
            EDGE_RISE: edge_det = src_sync[0] & ~src_sync[1];
            EDGE_FALL: edge_det = ~src_sync[0] & src_sync[1];
            EDGE_BOTH: edge_det = src_sync[0] ^ src_sync[1];
            default:   edge_det = 1'b0;
        endcase
    end

    assign cap_hit = edge_det & i_run;  // only while the counter runs.
    assign rd_rise = i_read_flag & ~rd_q;
    assign set_bit = cap_hit ? (CAP_SLOTS'(1) << ptr_q) : '0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            src_sync <= 2'b00;
            rd_q     <= '0;
            ptr_q    <= '0;
            status_q <= '0;
            slot_q   <= '0;
        end else if (!i_enable) begin
            src_sync <= 2'b00;
            rd_q     <= '0;
            ptr_q    <= '0;
            status_q <= '0;
            slot_q   <= '0;
        end else begin
            src_sync <= {src_sync[0], src_bit};
            rd_q     <= i_read_flag;
            // a capture on the slot wins over its read clear.
            status_q <= (status_q & ~rd_rise) | set_bit;
            if (cap_hit) begin
                if (!status_q[ptr_q] || i_overflow_ctrl[ptr_q]) begin
                    slot_q[ptr_q] <= i_count;
                end
                ptr_q <= (int'(ptr_q) == CAP_SLOTS - 1) ? '0 : ptr_q + 1'b1;
            end
        end
    end

    assign o_bank.cap0   = slot_q[0];
    assign o_bank.cap1   = slot_q[1];
    assign o_bank.cap2   = slot_q[2];
    assign o_bank.status = status_q;

    a_ptr_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        ptr_q < slot_idx_t'(CAP_SLOTS)
    ) else $error("slot pointer out of range");

    // slots move only on a qualified edge, or when cleared by disable.
    a_slot_on_edge: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $changed(slot_q) |-> ($past(cap_hit) || !$past(i_enable))
    ) else $error("capture slot changed without an edge");

endmodule

`default_nettype wire

// ==== design/capture_snapshot.sv ====
`timescale 1ns/1ns
`default_nettype none

module capture_snapshot #(
    parameter int COUNT_WIDTH = 32,
    parameter int CHANNELS    = 2
) (
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire  [COUNT_WIDTH-1:0]        i_count,
    input  wire  [1:0]                    i_ctrl_snap, // [0] shadow, [1] capture and status.
    cap_bank_if.consumer                  banks [CHANNELS],
    output logic [COUNT_WIDTH-1:0]        o_shadow,
    output logic [CHANNELS-1:0][timer_pkg::CAP_SLOTS-1:0][COUNT_WIDTH-1:0] o_capture,
    output logic [CHANNELS-1:0][timer_pkg::CAP_SLOTS-1:0] o_status,
    output logic [CHANNELS:0]             o_int        // top bit is counter overflow.
);
    import timer_pkg::*;

    logic [CHANNELS-1:0][CAP_SLOTS-1:0][COUNT_WIDTH-1:0] bank_cap;
    logic [CHANNELS-1:0][CAP_SLOTS-1:0]                  bank_status;
    logic [CHANNELS-1:0]                                 full_now;
    logic [CHANNELS-1:0]                                 full_q;
    logic                                                wrap_q;
    logic [1:0]                                          snap_q;
    logic [1:0]                                          snap_tgl;

    // flatten the bank array so the registers below can take it whole.
    for (genvar c = 0; c < CHANNELS; c++) begin : g_bank
        assign bank_cap[c]    = {banks[c].cap2, banks[c].cap1, banks[c].cap0};
        assign bank_status[c] = banks[c].status;
        assign full_now[c]    = &banks[c].status;
    end

    assign snap_tgl = i_ctrl_snap ^ snap_q; // either edge of a control bit.

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            snap_q <= 2'b00;
            full_q <= '0;
            wrap_q <= 1'b0;
        end else begin
            snap_q <= i_ctrl_snap;
            full_q <= full_now;
            wrap_q <= &i_count;  // counter sat at all ones.
        end
    end

    // output copies keep their value while the timer is disabled.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_shadow  <= '0;
            o_capture <= '0;
            o_status  <= '0;
        end else begin
            if (snap_tgl[0]) begin
                o_shadow <= i_count;
            end
            if (snap_tgl[1]) begin
                o_capture <= bank_cap;
                o_status  <= bank_status;
            end
        end
    end

    // pulses come from the history flops, so they sit in the cycle right after
    // the status fills up or the counter rolls over.
    assign o_int[CHANNELS-1:0] = full_now & ~full_q;
    assign o_int[CHANNELS]     = wrap_q & (i_count == '0);

    a_int_single: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_int & $past(o_int)) == '0
    ) else $error("interrupt held high for two cycles");

endmodule

`default_nettype wire

// ==== design/timer_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module timer_capture #(
    parameter int COUNT_WIDTH = 32,
    parameter int INNER_NUM   = 4,
    parameter int CHANNELS    = 2,
    localparam int SEL_WIDTH  = $clog2(INNER_NUM + 2)
) (
    input  wire                                   i_clk,
    input  wire                                   i_rst_n,
    input  wire                                   i_enable,
    input  wire                                   i_ext_a,
    input  wire                                   i_ext_b,
    input  wire  [INNER_NUM-1:0]                  i_inner_din,
    input  wire  [SEL_WIDTH-1:0]                  i_src_sel_start,
    input  timer_pkg::edge_sel_t                  i_edge_start,
    input  wire  [SEL_WIDTH-1:0]                  i_src_sel_stop,
    input  timer_pkg::edge_sel_t                  i_edge_stop,
    input  wire  [CHANNELS-1:0][SEL_WIDTH-1:0]    i_src_sel_cap,
    input  timer_pkg::edge_sel_t [CHANNELS-1:0]   i_edge_cap,
    input  wire  [CHANNELS-1:0][timer_pkg::CAP_SLOTS-1:0] i_overflow_ctrl,
    input  wire  [CHANNELS-1:0][timer_pkg::CAP_SLOTS-1:0] i_read_flag,
    input  wire  [1:0]                            i_ctrl_snap,
    output logic [COUNT_WIDTH-1:0]                o_shadow,
    output logic [CHANNELS-1:0][timer_pkg::CAP_SLOTS-1:0][COUNT_WIDTH-1:0] o_capture,
    output logic [CHANNELS-1:0][timer_pkg::CAP_SLOTS-1:0] o_status,
    output logic [CHANNELS:0]                     o_int
);

    logic                   run;
    logic [COUNT_WIDTH-1:0] count_value;

    cap_bank_if #(.COUNT_WIDTH(COUNT_WIDTH)) bank_if [CHANNELS] ();

    capture_timebase #(
        .COUNT_WIDTH (COUNT_WIDTH),
        .INNER_NUM   (INNER_NUM)
    ) u_timebase (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_enable        (i_enable),
        .i_ext_a         (i_ext_a),
        .i_ext_b         (i_ext_b),
        .i_inner_din     (i_inner_din),
        .i_src_sel_start (i_src_sel_start),
        .i_src_sel_stop  (i_src_sel_stop),
        .i_edge_start    (i_edge_start),
        .i_edge_stop     (i_edge_stop),
        .o_run           (run),
        .o_count         (count_value)
    );

    // identical capture channels, each on its own source and edge.
    for (genvar c = 0; c < CHANNELS; c++) begin : g_chan
        capture_channel #(
            .COUNT_WIDTH (COUNT_WIDTH),
            .INNER_NUM   (INNER_NUM)
        ) u_channel (
            .i_clk           (i_clk),
            .i_rst_n         (i_rst_n),
            .i_enable        (i_enable),
            .i_run           (run),
            .i_count         (count_value),
            .i_ext_a         (i_ext_a),
            .i_ext_b         (i_ext_b),
            .i_inner_din     (i_inner_din),
            .i_src_sel       (i_src_sel_cap[c]),
            .i_edge          (i_edge_cap[c]),
            .i_overflow_ctrl (i_overflow_ctrl[c]),
            .i_read_flag     (i_read_flag[c]),
            .o_bank          (bank_if[c])
        );
    end

    capture_snapshot #(
        .COUNT_WIDTH (COUNT_WIDTH),
        .CHANNELS    (CHANNELS)
    ) u_snapshot (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_count     (count_value),
        .i_ctrl_snap (i_ctrl_snap),
        .banks       (bank_if),
        .o_shadow    (o_shadow),
        .o_capture   (o_capture),
        .o_status    (o_status),
        .o_int       (o_int)
    );

endmodule

`default_nettype wire

// ==== verification/timer_capture_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module timer_capture_tb;
    import timer_pkg::*;

    localparam int BIG = 1 << 30;

    logic                  i_clk, i_rst_n, i_enable, i_ext_a, i_ext_b;
    logic [3:0]            inner;
    logic [2:0]            sel_start, sel_stop;
    edge_sel_t             edge_start, edge_stop;
    logic [1:0][2:0]       sel_cap;
    edge_sel_t [1:0]       edge_cap;
    logic [1:0][2:0]       ovf, rd;
    logic [1:0]            snap;
    logic [7:0]            shadow;
    logic [1:0][2:0][7:0]  capture;
    logic [1:0][2:0]       status;
    logic [2:0]            intr;

    // testbench model state.
    int                    cyc = 0;
    int                    m_count = 0, m_prev = 0;
    int                    seg_base = 0, seg_start = -1, seg_stop = BIG;
    logic [1:0][2:0][7:0]  m_slot = '0, exp_cap = '0;
    logic [1:0][2:0]       m_stat = '0, exp_stat = '0;
    int                    m_ptr [2] = '{0, 0};
    int                    full_at [2] = '{-1, -1};
    int                    exp_shadow = 0, stop_snap = 0;
    logic                  rst_chk = 0, shadow_chk = 0, cap_chk = 0, eq_chk = 0, incr_chk = 0;
    int                    errors = 0, tests_ok = 0, tests_bad = 0, wraps_seen = 0;

    timer_capture #(.COUNT_WIDTH(8), .INNER_NUM(4), .CHANNELS(2)) UUT (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_enable(i_enable),
        .i_ext_a(i_ext_a), .i_ext_b(i_ext_b), .i_inner_din(inner),
        .i_src_sel_start(sel_start), .i_edge_start(edge_start),
        .i_src_sel_stop(sel_stop), .i_edge_stop(edge_stop),
        .i_src_sel_cap(sel_cap), .i_edge_cap(edge_cap),
        .i_overflow_ctrl(ovf), .i_read_flag(rd), .i_ctrl_snap(snap),
        .o_shadow(shadow), .o_capture(capture), .o_status(status), .o_int(intr)
    );

    always #50 i_clk = ~i_clk;

    // counter value expected after edge n under the start and stop timing.
    function automatic int model_count(input int n);
        int hi;
        if (seg_start < 0) return seg_base;
        hi = (n < seg_stop) ? n : seg_stop;
        if (hi < seg_start) hi = seg_start;
        return (seg_base + hi - seg_start) % 256;
    endfunction

    always @(posedge i_clk) begin
        cyc     <= cyc + 1;
        m_count <= model_count(cyc + 1);
        m_prev  <= m_count;
    end

    a_reset: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        rst_chk |-> (shadow == '0 && capture == '0 && status == '0 && intr == '0))
        else begin
            errors++;
            $display("FAIL %0t: outputs not zero after reset", $time);
        end

    a_shadow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        shadow_chk |-> shadow == exp_shadow[7:0])
        else begin
            errors++;
            $display("FAIL %0t: shadow %0d, expected %0d", $time, $sampled(shadow),
                     $sampled(exp_shadow));
        end

    a_stop_equal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        eq_chk |-> shadow == stop_snap[7:0])
        else begin
            errors++;
            $display("FAIL %0t: shadow moved after stop", $time);
        end

    a_capture: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        cap_chk |-> (capture == exp_cap && status == exp_stat))
        else begin
            errors++;
            $display("FAIL %0t: capture %h status %b, expected %h %b", $time,
                     $sampled(capture), $sampled(status),
                     $sampled(exp_cap), $sampled(exp_stat));
        end

    a_increasing: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        incr_chk |-> (capture[0][0] < capture[0][1] && capture[0][1] < capture[0][2]))
        else begin
            errors++;
            $display("FAIL %0t: channel 0 slots not increasing", $time);
        end

    // wrap pulse sits in the cycle after the all-ones to zero step.
    a_wrap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        intr[2] == (m_count == 0 && m_prev == 255))
        else begin
            errors++;
            $display("FAIL %0t: overflow interrupt %b wrong", $time, $sampled(intr[2]));
        end

    for (genvar c = 0; c < 2; c++) begin : g_full
        a_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            intr[c] == (cyc == full_at[c]))
            else begin
                errors++;
                $display("FAIL %0t: full interrupt %0d wrong", $time, c);
            end
    end

    task automatic wait_gap();
        repeat ($urandom_range(12, 3)) @(posedge i_clk);
    endtask

    task automatic start_counter();
        int k;
        @(posedge i_clk);
        i_ext_a <= 1'b1;
        k = cyc + 1;
        seg_base  = model_count(k); // held value.
        seg_start = k + 2;
        seg_stop  = BIG;
        wait_gap();
        @(posedge i_clk);
        i_ext_a <= 1'b0;
        wait_gap();
    endtask

    task automatic stop_counter();
        @(posedge i_clk);
        i_ext_b <= 1'b1;
        seg_stop = cyc + 3;
        wait_gap();
        @(posedge i_clk);
        i_ext_b <= 1'b0;
        wait_gap();
    endtask

    task automatic snap_shadow(output int v);
        @(posedge i_clk);
        snap[0] <= ~snap[0];
        v = model_count(cyc + 1);
        @(posedge i_clk);
        exp_shadow <= v;
        shadow_chk <= 1'b1;
        wait_gap();
    endtask

    task automatic snap_capture();
        @(posedge i_clk);
        snap[1] <= ~snap[1];
        @(posedge i_clk);
        exp_cap  <= m_slot;
        exp_stat <= m_stat;
        cap_chk  <= 1'b1;
        wait_gap();
    endtask

    // an unread slot is kept when overwrite is off.
    task automatic model_capture(input int ch, input int val, input int at);
        int  p;
        logic was_full;
        p = m_ptr[ch];
        was_full = &m_stat[ch];
        if (!m_stat[ch][p] || ovf[ch][p]) m_slot[ch][p] = val[7:0];
        m_stat[ch][p] = 1'b1;
        m_ptr[ch] = (p == 2) ? 0 : p + 1;
        if (!was_full && &m_stat[ch]) full_at[ch] = at;
    endtask

    task automatic toggle_inner(input int idx, input int ch, input logic hit);
        int k;
        @(posedge i_clk);
        inner[idx] <= ~inner[idx];
        k = cyc + 1;
        if (hit) model_capture(ch, model_count(k + 1), k + 2);
        wait_gap();
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int   e, v, n;
        logic seen;
        void'($urandom(11));
        i_clk = 0;
        i_rst_n = 0;
        i_enable = 1;
        i_ext_a = 0;
        i_ext_b = 0;
        inner = 4'b0010; // ch0 source idles high for falling edges.
        sel_start = SRC_EXT_A;
        sel_stop = SRC_EXT_B;
        edge_start = EDGE_RISE;
        edge_stop = EDGE_RISE;
        sel_cap[0] = 3'd3; // inner 1.
        sel_cap[1] = 3'd4; // inner 2.
        edge_cap[0] = EDGE_FALL;
        edge_cap[1] = EDGE_RISE;
        ovf = '0;
        rd = '0;
        snap = 2'b00;
        repeat (5) @(posedge i_clk);
        i_rst_n <= 1'b1;

        e = errors;
        @(posedge i_clk);
        rst_chk <= 1'b1;
        repeat (3) @(posedge i_clk);
        rst_chk <= 1'b0;
        finish_test("reset", e);

        e = errors;
        start_counter();
        snap_shadow(v);
        stop_counter();
        snap_shadow(stop_snap);
        snap_shadow(v);
        eq_chk <= 1'b1;
        @(posedge i_clk);
        eq_chk <= 1'b0;
        finish_test("start stop", e);

        e = errors;
        start_counter();
        for (int i = 0; i < 3; i++) begin
            toggle_inner(1, 0, 1'b1); // falling, captures.
            toggle_inner(1, 0, 1'b0);
        end
        snap_capture();
        incr_chk <= 1'b1;
        @(posedge i_clk);
        incr_chk <= 1'b0;
        finish_test("three slots", e);

        e = errors;
        toggle_inner(1, 0, 1'b1);
        toggle_inner(1, 0, 1'b0);
        snap_capture();
        @(posedge i_clk);
        ovf[0][0] <= 1'b1;
        for (int i = 0; i < 3; i++) begin
            toggle_inner(1, 0, 1'b1);
            toggle_inner(1, 0, 1'b0);
        end
        snap_capture();
        finish_test("overflow control", e);

        e = errors;
        for (int i = 0; i < 2; i++) begin
            toggle_inner(2, 1, 1'b1); // rising, captures.
            toggle_inner(2, 1, 1'b0);
        end
        snap_capture();
        @(posedge i_clk);
        rd[1][1] <= 1'b1;
        m_stat[1][1] = 1'b0;
        wait_gap();
        snap_capture();
        @(posedge i_clk);
        edge_cap[1] <= EDGE_NONE;
        repeat (4) toggle_inner(2, 1, 1'b0);
        snap_capture();
        finish_test("read flag and edge none", e);

        e = errors;
        for (int w = 0; w < 2; w++) begin
            seen = 1'b0;
            n = 0;
            while (!seen && n < 300) begin
                @(posedge i_clk);
                if (intr[2]) seen = 1'b1;
                n++;
            end
            if (seen) begin
                wraps_seen++;
            end else begin
                errors++;
                $display("timeout waiting for counter overflow interrupt %0d", w);
            end
        end
        finish_test("wrap interrupt", e);

        $display("%0d tests ok, %0d tests failed, %0d errors, %0d wraps", tests_ok, tests_bad,
                 errors, wraps_seen);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== timer_capture.f ====
design/timer_pkg.sv
design/cap_bank_if.sv
design/capture_timebase.sv
design/capture_channel.sv
design/capture_snapshot.sv
design/timer_capture.sv
verification/timer_capture_tb.sv
